// File: hdl/y86_fetch_pkg.sv
`default_nettype none

package y86_fetch_pkg;

    // longest y86 instruction in bytes
    localparam int WINDOW_BYTES = 10;

    // data and address word
    typedef logic [63:0] word_t;
    // one memory byte
    typedef logic [7:0] byte_t;
    // icode, ifun, register id
    typedef logic [3:0] nibble_t;
    // pipeline status code
    typedef logic [2:0] stat_t;
    // bytes pc .. pc+9 with byte 0 in the low bits
    typedef logic [WINDOW_BYTES*8-1:0] window_t;

    // instruction memory geometry
    localparam int IMEM_AW = 16;
    localparam int IMEM_BYTES = 65536;

    // fetch address after reset
    localparam word_t RESET_PC = 64'h0;

    // opcodes, low nibble of byte 0
    localparam nibble_t I_HALT = 4'h0;
    localparam nibble_t I_NOP = 4'h1;
    // also cmovXX
    localparam nibble_t I_RRMOVQ = 4'h2;
    localparam nibble_t I_IRMOVQ = 4'h3;
    localparam nibble_t I_RMMOVQ = 4'h4;
    localparam nibble_t I_MRMOVQ = 4'h5;
    localparam nibble_t I_OPQ = 4'h6;
    localparam nibble_t I_JXX = 4'h7;
    localparam nibble_t I_CALL = 4'h8;
    localparam nibble_t I_RET = 4'h9;
    localparam nibble_t I_PUSHQ = 4'ha;
    localparam nibble_t I_POPQ = 4'hb;

    // status codes
    localparam stat_t S_AOK = 3'd0;
    localparam stat_t S_ADR = 3'd2;
    localparam stat_t S_INS = 3'd3;
    localparam stat_t S_HLT = 3'd4;

    // register id meaning no register
    localparam nibble_t R_NONE = 4'hf;

endpackage

`default_nettype wire

// File: hdl/pc_select.sv
`timescale 1ns/1ns
`default_nettype none

module pc_select
(
    input wire clk,
    input wire arst_n,

    // redirect sources from later stages
    input wire y86_fetch_pkg::nibble_t w_icode,
    input wire y86_fetch_pkg::nibble_t m_icode,
    input wire m_cnd,
    input wire y86_fetch_pkg::word_t w_valm,
    input wire y86_fetch_pkg::word_t m_vala,

    // decoded fields of the instruction at pc
    input wire y86_fetch_pkg::nibble_t icode,
    input wire y86_fetch_pkg::word_t valc,
    input wire y86_fetch_pkg::word_t valp,

    output y86_fetch_pkg::word_t pc,
    output y86_fetch_pkg::word_t pred_pc
);

    // predicted pc held in the F stage register
    y86_fetch_pkg::word_t pred_q;

    // ret in write-back wins since its target is only known now
    // then a not-taken jump in memory whose valA carries the fall-through
    // otherwise follow the prediction
    always_comb
    begin
        if (w_icode == y86_fetch_pkg::I_RET)
        begin
            pc = w_valm;
        end
        else if (m_icode == y86_fetch_pkg::I_JXX && !m_cnd)
        begin
            pc = m_vala;
        end
        else
        begin
            pc = pred_q;
        end
    end

    // jumps predicted taken
    // call always goes to its target
    always_comb
    begin
        if (icode == y86_fetch_pkg::I_JXX || icode == y86_fetch_pkg::I_CALL)
        begin
            pred_pc = valc;
        end
        else
        begin
            // ret also lands here and is corrected from write-back
            pred_pc = valp;
        end
    end

    // one fetch per clock with no stall
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pred_q <= y86_fetch_pkg::RESET_PC;
        end
        else
        begin
            pred_q <= pred_pc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/imem.sv
`timescale 1ns/1ns
`default_nettype none

module imem
(
    input wire clk,

    // byte load port for placing the program
    input wire imem_we,
    input wire y86_fetch_pkg::word_t imem_waddr,
    input wire y86_fetch_pkg::byte_t imem_wdata,

    // fetch address
    input wire y86_fetch_pkg::word_t pc,

    output y86_fetch_pkg::window_t window,
    output logic imem_error
);

    // byte array
    y86_fetch_pkg::byte_t mem [y86_fetch_pkg::IMEM_BYTES];

    // synchronous write seen by reads from the next cycle
    // addresses past the end are dropped
    always_ff @(posedge clk)
    begin
        if (imem_we && imem_waddr < y86_fetch_pkg::word_t'(y86_fetch_pkg::IMEM_BYTES))
        begin
            mem[imem_waddr[y86_fetch_pkg::IMEM_AW-1:0]] <= imem_wdata;
        end
    end

    // fetch address outside the memory
    assign imem_error = (pc >= y86_fetch_pkg::word_t'(y86_fetch_pkg::IMEM_BYTES));

    // combinational read of pc .. pc+9
    always_comb
    begin
        // one extra bit catches running off the top
        logic [y86_fetch_pkg::IMEM_AW:0] addr;

        window = '0;
        for (int i = 0; i < y86_fetch_pkg::WINDOW_BYTES; i++)
        begin
            addr = {1'b0, pc[y86_fetch_pkg::IMEM_AW-1:0]} + (y86_fetch_pkg::IMEM_AW+1)'(i);
            // bytes past the end read as zero
            if (!imem_error && !addr[y86_fetch_pkg::IMEM_AW])
            begin
                window[i*8 +: 8] = mem[addr[y86_fetch_pkg::IMEM_AW-1:0]];
            end
            else
            begin
                window[i*8 +: 8] = 8'h00;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/inst_split.sv
`timescale 1ns/1ns
`default_nettype none

module inst_split
(
    input wire y86_fetch_pkg::word_t pc,
    input wire y86_fetch_pkg::window_t window,
    input wire imem_error,

    output y86_fetch_pkg::nibble_t icode,
    output y86_fetch_pkg::nibble_t ifun,
    output y86_fetch_pkg::nibble_t ra,
    output y86_fetch_pkg::nibble_t rb,
    output y86_fetch_pkg::word_t valc,
    output y86_fetch_pkg::word_t valp,
    output y86_fetch_pkg::stat_t stat
);

    // instruction has a register byte
    logic need_regids;
    // constant starts after the regids or right after byte 0
    logic valc_at_2;
    logic valc_at_1;
    // icode/ifun combination is legal
    logic inst_valid;
    // length in bytes from 1 to 10
    logic [3:0] ilen;

    // icode in the low nibble and ifun in the high one
    assign icode = window[3:0];
    assign ifun = window[7:4];

    // decode classes per icode
    always_comb
    begin
        need_regids = 1'b0;
        valc_at_2 = 1'b0;
        valc_at_1 = 1'b0;
        case (icode)
            y86_fetch_pkg::I_RRMOVQ,
            y86_fetch_pkg::I_OPQ,
            y86_fetch_pkg::I_PUSHQ,
            y86_fetch_pkg::I_POPQ:
            begin
                need_regids = 1'b1;
            end
            y86_fetch_pkg::I_IRMOVQ,
            y86_fetch_pkg::I_RMMOVQ,
            y86_fetch_pkg::I_MRMOVQ:
            begin
                need_regids = 1'b1;
                valc_at_2 = 1'b1;
            end
            y86_fetch_pkg::I_JXX,
            y86_fetch_pkg::I_CALL:
            begin
                valc_at_1 = 1'b1;
            end
            default:
            begin
                // halt, nop, ret and bad icodes
                need_regids = 1'b0;
            end
        endcase
    end

    // ra in the low nibble of byte 1
    assign ra = need_regids ? window[11:8] : y86_fetch_pkg::R_NONE;
    assign rb = need_regids ? window[15:12] : y86_fetch_pkg::R_NONE;

    // little-endian constant already byte ordered in the window
    always_comb
    begin
        if (valc_at_2)
        begin
            valc = window[79:16];
        end
        else if (valc_at_1)
        begin
            valc = window[71:8];
        end
        else
        begin
            valc = '0;
        end
    end

    // ifun legality per icode
    always_comb
    begin
        case (icode)
            y86_fetch_pkg::I_OPQ:
                inst_valid = (ifun <= 4'd3);
            y86_fetch_pkg::I_JXX,
            y86_fetch_pkg::I_RRMOVQ:
                inst_valid = (ifun <= 4'd6);
            y86_fetch_pkg::I_HALT,
            y86_fetch_pkg::I_NOP,
            y86_fetch_pkg::I_IRMOVQ,
            y86_fetch_pkg::I_RMMOVQ,
            y86_fetch_pkg::I_MRMOVQ,
            y86_fetch_pkg::I_CALL,
            y86_fetch_pkg::I_RET,
            y86_fetch_pkg::I_PUSHQ,
            y86_fetch_pkg::I_POPQ:
                inst_valid = (ifun == 4'd0);
            default:
                // icode 12..15
                inst_valid = 1'b0;
        endcase
    end

    // length follows the operand layout
    // bad instructions step one byte
    always_comb
    begin
        if (!inst_valid)
        begin
            ilen = 4'd1;
        end
        else if (valc_at_2)
        begin
            ilen = 4'd10;
        end
        else if (valc_at_1)
        begin
            ilen = 4'd9;
        end
        else if (need_regids)
        begin
            ilen = 4'd2;
        end
        else
        begin
            ilen = 4'd1;
        end
    end

    assign valp = pc + y86_fetch_pkg::word_t'(ilen);

    // INS beats ADR beats HLT
    always_comb
    begin
        if (!inst_valid)
            stat = y86_fetch_pkg::S_INS;
        else if (imem_error)
            stat = y86_fetch_pkg::S_ADR;
        else if (icode == y86_fetch_pkg::I_HALT)
            stat = y86_fetch_pkg::S_HLT;
        else
            stat = y86_fetch_pkg::S_AOK;
    end

endmodule

`default_nettype wire

// File: hdl/fetch.sv
`timescale 1ns/1ns
`default_nettype none

module fetch
(
    input wire clk,
    input wire arst_n,

    // program load port
    input wire imem_we,
    input wire y86_fetch_pkg::word_t imem_waddr,
    input wire y86_fetch_pkg::byte_t imem_wdata,

    // redirects from write-back and memory stages
    input wire y86_fetch_pkg::nibble_t w_icode,
    input wire y86_fetch_pkg::word_t w_valm,
    input wire y86_fetch_pkg::nibble_t m_icode,
    input wire m_cnd,
    input wire y86_fetch_pkg::word_t m_vala,

    // fetched instruction combinational within this cycle
    output wire y86_fetch_pkg::word_t pc,
    output wire y86_fetch_pkg::nibble_t icode,
    output wire y86_fetch_pkg::nibble_t ifun,
    output wire y86_fetch_pkg::nibble_t ra,
    output wire y86_fetch_pkg::nibble_t rb,
    output wire y86_fetch_pkg::word_t valc,
    output wire y86_fetch_pkg::word_t valp,
    output wire y86_fetch_pkg::stat_t stat,
    output wire y86_fetch_pkg::word_t pred_pc
);

    // memory to splitter
    wire y86_fetch_pkg::window_t window;
    wire imem_error;

    // pc mux and prediction
    // loop closes through icode/valc/valp
    pc_select u_pc_select
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .w_icode (w_icode),
        .m_icode (m_icode),
        .m_cnd   (m_cnd),
        .w_valm  (w_valm),
        .m_vala  (m_vala),
        .icode   (icode),
        .valc    (valc),
        .valp    (valp),
        .pc      (pc),
        .pred_pc (pred_pc)
    );

    // instruction bytes at pc
    imem u_imem
    (
        .clk        (clk),
        .imem_we    (imem_we),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .pc         (pc),
        .window     (window),
        .imem_error (imem_error)
    );

    // field split, length and status
    inst_split u_inst_split
    (
        .pc         (pc),
        .window     (window),
        .imem_error (imem_error),
        .icode      (icode),
        .ifun       (ifun),
        .ra         (ra),
        .rb         (rb),
        .valc       (valc),
        .valp       (valp),
        .stat       (stat)
    );

endmodule

`default_nettype wire

// File: sim/fetch_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_checker
(
    input wire clk,
    input wire arst_n,
    input wire y86_fetch_pkg::nibble_t w_icode,
    input wire y86_fetch_pkg::word_t w_valm,
    input wire y86_fetch_pkg::nibble_t m_icode,
    input wire m_cnd,
    input wire y86_fetch_pkg::word_t m_vala,
    input wire y86_fetch_pkg::word_t pc,
    input wire y86_fetch_pkg::nibble_t icode,
    input wire y86_fetch_pkg::nibble_t ifun,
    input wire y86_fetch_pkg::word_t valc,
    input wire y86_fetch_pkg::word_t valp,
    input wire y86_fetch_pkg::stat_t stat,
    input wire imem_error
);

    // assertion failures so far
    int unsigned fail_count = 0;

    logic ret_redirect;
    logic jmp_redirect;
    logic legal;
    logic to_target;

    assign ret_redirect = (w_icode == y86_fetch_pkg::I_RET);
    // not-taken jump only counts when no ret is pending
    assign jmp_redirect = !ret_redirect && m_icode == y86_fetch_pkg::I_JXX && !m_cnd;
    assign to_target = (icode == y86_fetch_pkg::I_JXX || icode == y86_fetch_pkg::I_CALL);

    // icode 1 to 11 with an allowed ifun
    // halt left out
    assign legal = (icode == y86_fetch_pkg::I_OPQ && ifun <= 4'd3)
        || ((icode == y86_fetch_pkg::I_RRMOVQ || icode == y86_fetch_pkg::I_JXX) && ifun <= 4'd6)
        || (icode >= y86_fetch_pkg::I_NOP && icode <= y86_fetch_pkg::I_POPQ && ifun == 4'd0);

    a_ret_redirect : assert property (@(posedge clk) disable iff (!arst_n)
        ret_redirect |-> pc == w_valm)
    else
    begin
        fail_count++;
        $error("pc did not take the ret address from write-back");
    end

    a_jmp_redirect : assert property (@(posedge clk) disable iff (!arst_n)
        jmp_redirect |-> pc == m_vala)
    else
    begin
        fail_count++;
        $error("pc did not take the fall-through of the not-taken jump");
    end

    // straight-line flow follows valp
    a_follow_valp : assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) && !ret_redirect && !jmp_redirect && !$past(to_target)
        |-> pc == $past(valp))
    else
    begin
        fail_count++;
        $error("pc is not the valp of the previous instruction");
    end

    // jXX predicted taken and call always
    a_follow_valc : assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) && !ret_redirect && !jmp_redirect && $past(to_target)
        |-> pc == $past(valc))
    else
    begin
        fail_count++;
        $error("pc is not the target of the previous jump or call");
    end

    a_stat_aok : assert property (@(posedge clk) disable iff (!arst_n)
        legal && !imem_error |-> stat == y86_fetch_pkg::S_AOK)
    else
    begin
        fail_count++;
        $error("legal instruction inside memory without AOK status");
    end

endmodule

bind fetch fetch_checker u_fetch_checker
(
    .clk        (clk),
    .arst_n     (arst_n),
    .w_icode    (w_icode),
    .w_valm     (w_valm),
    .m_icode    (m_icode),
    .m_cnd      (m_cnd),
    .m_vala     (m_vala),
    .pc         (pc),
    .icode      (icode),
    .ifun       (ifun),
    .valc       (valc),
    .valp       (valp),
    .stat       (stat),
    .imem_error (imem_error)
);

`default_nettype wire

// File: sim/tb_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch;

    localparam int CLK_NS = 4;
    // cycle budgets of reset, straight, jump, redirect, status, random
    localparam int BUDGET = 15 + 60 + 45 + 25 + 25 + 130;
    // straight-line opcodes for the random stream
    localparam y86_fetch_pkg::nibble_t POOL [8] = '{4'h1, 4'h2, 4'h3, 4'h4,
                                                    4'h5, 4'h6, 4'ha, 4'hb};

    logic clk = 1'b0;
    logic arst_n;
    logic imem_we;
    y86_fetch_pkg::word_t imem_waddr;
    y86_fetch_pkg::byte_t imem_wdata;
    y86_fetch_pkg::nibble_t w_icode;
    y86_fetch_pkg::word_t w_valm;
    y86_fetch_pkg::nibble_t m_icode;
    logic m_cnd;
    y86_fetch_pkg::word_t m_vala;

    wire y86_fetch_pkg::word_t pc;
    wire y86_fetch_pkg::nibble_t icode;
    wire y86_fetch_pkg::nibble_t ifun;
    wire y86_fetch_pkg::nibble_t ra;
    wire y86_fetch_pkg::nibble_t rb;
    wire y86_fetch_pkg::word_t valc;
    wire y86_fetch_pkg::word_t valp;
    wire y86_fetch_pkg::stat_t stat;
    wire y86_fetch_pkg::word_t pred_pc;

    // mirror of every memory write
    y86_fetch_pkg::byte_t shadow [y86_fetch_pkg::IMEM_BYTES];
    // bytes waiting to be loaded
    y86_fetch_pkg::word_t prog_addr [$];
    y86_fetch_pkg::byte_t prog_data [$];
    y86_fetch_pkg::word_t wp = '0;
    y86_fetch_pkg::word_t exp_pred;
    y86_fetch_pkg::stat_t last_stat;
    logic [31:0] lfsr = 32'h6d75;
    string cur_test;
    int test_errs;
    int clean_tests = 0;
    int bad_tests = 0;

    fetch u_fetch (.*);

    initial
    begin
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // run length bound at twice the summed budgets
    initial
    begin
        #(2 * BUDGET * CLK_NS);
        $display("watchdog expired after %0d cycles, run did not finish", 2 * BUDGET);
        $display("test failed");
        $finish;
    end

    // fibonacci lfsr with taps 32 22 2 1
    // one step per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic emit(input y86_fetch_pkg::byte_t b);
        prog_addr.push_back(wp);
        prog_data.push_back(b);
        wp++;
    endtask

    // little-endian with the low byte first
    task automatic emit_word(input y86_fetch_pkg::word_t w);
        for (int k = 0; k < 8; k++)
            emit(w[8*k +: 8]);
    endtask

    // expected fetch result at address a from the shadow bytes
    function automatic void decode_at(input y86_fetch_pkg::word_t a,
        output y86_fetch_pkg::nibble_t ic, output y86_fetch_pkg::nibble_t fn,
        output y86_fetch_pkg::nibble_t r_a, output y86_fetch_pkg::nibble_t r_b,
        output y86_fetch_pkg::word_t vc, output y86_fetch_pkg::word_t vp,
        output y86_fetch_pkg::stat_t st);
        y86_fetch_pkg::byte_t b [10];
        y86_fetch_pkg::word_t ai;
        int len;
        int off;
        logic regs;
        logic ok;
        for (int i = 0; i < 10; i++)
        begin
            ai = a + y86_fetch_pkg::word_t'(i);
            b[i] = (ai < y86_fetch_pkg::IMEM_BYTES) ? shadow[ai[15:0]] : 8'h00;
        end
        ic = b[0][3:0];
        fn = b[0][7:4];
        regs = 1'b0;
        off = 0;
        len = 1;
        case (ic)
            4'h2, 4'h6, 4'ha, 4'hb:
            begin
                regs = 1'b1;
                len = 2;
            end
            4'h3, 4'h4, 4'h5:
            begin
                regs = 1'b1;
                off = 2;
                len = 10;
            end
            4'h7, 4'h8:
            begin
                off = 1;
                len = 9;
            end
            default:
                len = 1;
        endcase
        // opq takes 4 functions
        // jXX and cmovXX take 7
        if (ic == 4'h6)
            ok = (fn <= 4'd3);
        else if (ic == 4'h2 || ic == 4'h7)
            ok = (fn <= 4'd6);
        else
            ok = (ic <= 4'hb) && (fn == 4'd0);
        r_a = regs ? b[1][3:0] : y86_fetch_pkg::R_NONE;
        r_b = regs ? b[1][7:4] : y86_fetch_pkg::R_NONE;
        vc = '0;
        if (off != 0)
        begin
            for (int k = 0; k < 8; k++)
                vc[8*k +: 8] = b[off + k];
        end
        vp = a + y86_fetch_pkg::word_t'(ok ? len : 1);
        if (!ok)
            st = y86_fetch_pkg::S_INS;
        else if (a >= y86_fetch_pkg::IMEM_BYTES)
            st = y86_fetch_pkg::S_ADR;
        else if (ic == 4'h0)
            st = y86_fetch_pkg::S_HLT;
        else
            st = y86_fetch_pkg::S_AOK;
    endfunction

    task automatic compare(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
        assert (act_v === exp_v)
        else
        begin
            $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic idle_redirects();
        w_icode <= y86_fetch_pkg::I_NOP;
        w_valm <= '0;
        m_icode <= y86_fetch_pkg::I_NOP;
        m_cnd <= 1'b0;
        m_vala <= '0;
    endtask

    // holds reset for at least 10 cycles while the bytes go in
    task automatic load_program();
        int n;
        n = prog_addr.size();
        arst_n <= 1'b0;
        idle_redirects();
        for (int i = 0; i < n || i < 10; i++)
        begin
            if (i < n)
            begin
                imem_we <= 1'b1;
                imem_waddr <= prog_addr[i];
                imem_wdata <= prog_data[i];
                shadow[prog_addr[i][15:0]] = prog_data[i];
            end
            else
                imem_we <= 1'b0;
            @(posedge clk);
        end
        imem_we <= 1'b0;
        arst_n <= 1'b1;
        prog_addr.delete();
        prog_data.delete();
        wp = '0;
        exp_pred = y86_fetch_pkg::RESET_PC;
    endtask

    // sample mid-cycle and return on the next rising edge
    task automatic run_cycle();
        y86_fetch_pkg::word_t fpc;
        y86_fetch_pkg::nibble_t e_ic;
        y86_fetch_pkg::nibble_t e_fn;
        y86_fetch_pkg::nibble_t e_ra;
        y86_fetch_pkg::nibble_t e_rb;
        y86_fetch_pkg::word_t e_vc;
        y86_fetch_pkg::word_t e_vp;
        y86_fetch_pkg::stat_t e_st;
        @(negedge clk);
        if (w_icode == y86_fetch_pkg::I_RET)
            fpc = w_valm;
        else if (m_icode == y86_fetch_pkg::I_JXX && !m_cnd)
            fpc = m_vala;
        else
            fpc = exp_pred;
        decode_at(fpc, e_ic, e_fn, e_ra, e_rb, e_vc, e_vp, e_st);
        exp_pred = (e_ic == 4'h7 || e_ic == 4'h8) ? e_vc : e_vp;
        compare("pc", fpc, pc);
        compare("icode", e_ic, icode);
        compare("ifun", e_fn, ifun);
        compare("ra", e_ra, ra);
        compare("rb", e_rb, rb);
        compare("valc", e_vc, valc);
        compare("valp", e_vp, valp);
        compare("stat", e_st, stat);
        compare("pred_pc", exp_pred, pred_pc);
        last_stat = e_st;
        @(posedge clk);
    endtask

    task automatic run_until_halt(input int max_cycles);
        int k;
        k = 0;
        do
        begin
            run_cycle();
            k++;
        end
        while (last_stat != y86_fetch_pkg::S_HLT && k < max_cycles);
        if (last_stat != y86_fetch_pkg::S_HLT)
        begin
            $display("%s: no halt reached within %0d cycles", cur_test, max_cycles);
            test_errs++;
        end
    endtask

    // all pool opcodes but nop have a register byte
    task automatic build_random(input int count);
        y86_fetch_pkg::nibble_t ic;
        y86_fetch_pkg::nibble_t fn;
        for (int i = 0; i < count; i++)
        begin
            ic = POOL[take_bits(3)];
            fn = 4'h0;
            if (ic == y86_fetch_pkg::I_OPQ)
                fn = 4'(take_bits(2));
            else if (ic == y86_fetch_pkg::I_RRMOVQ)
                fn = 4'(take_bits(3) % 7);
            emit({fn, ic});
            if (ic != y86_fetch_pkg::I_NOP)
                emit(8'(take_bits(8)));
            if (ic inside {4'h3, 4'h4, 4'h5})
                emit_word(take_bits(64));
        end
        emit(8'h00);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0)
            clean_tests++;
        else
            bad_tests++;
        $display("[%s] finished, %0d mismatches", cur_test, test_errs);
    endtask

    initial
    begin
        arst_n = 1'b0;
        imem_we = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
        w_icode = y86_fetch_pkg::I_NOP;
        w_valm = '0;
        m_icode = y86_fetch_pkg::I_NOP;
        m_cnd = 1'b0;
        m_vala = '0;
        @(posedge clk);

        // first fetch at RESET_PC
        begin_test("reset");
        emit(8'h10);
        emit(8'h00);
        load_program();
        run_until_halt(4);
        end_test();

        begin_test("straight");
        emit(8'h10);
        emit(8'h02);
        emit(8'h21);
        emit(8'h03);
        emit(8'h3f);
        emit_word(64'h0123_4567_89ab_cdef);
        emit(8'h04);
        emit(8'h41);
        emit_word(64'h10);
        emit(8'h05);
        emit(8'h14);
        emit_word(64'h18);
        emit(8'h16);
        emit(8'h23);
        emit(8'h0a);
        emit(8'hf4);
        emit(8'h0b);
        emit(8'hf5);
        emit(8'h00);
        load_program();
        run_until_halt(10);
        end_test();

        // jmp, call, jle chained to a halt
        begin_test("jump");
        emit(8'h07);
        emit_word(64'h20);
        wp = 64'h20;
        emit(8'h08);
        emit_word(64'h40);
        wp = 64'h40;
        emit(8'h17);
        emit_word(64'h60);
        wp = 64'h60;
        emit(8'h00);
        load_program();
        run_until_halt(6);
        end_test();

        begin_test("redirect");
        emit(8'h10);
        wp = 64'h30;
        emit(8'h10);
        wp = 64'h50;
        emit(8'h10);
        emit(8'h00);
        load_program();
        // ret beats the not-taken jump
        w_icode <= y86_fetch_pkg::I_RET;
        w_valm <= 64'h30;
        m_icode <= y86_fetch_pkg::I_JXX;
        m_cnd <= 1'b0;
        m_vala <= 64'h50;
        run_cycle();
        w_icode <= y86_fetch_pkg::I_NOP;
        run_cycle();
        // taken jump leaves the prediction alone
        m_cnd <= 1'b1;
        run_cycle();
        end_test();

        // bad icode, nop with ifun, halt, then off the end
        begin_test("status");
        emit(8'h0c);
        emit(8'h11);
        emit(8'h00);
        load_program();
        run_until_halt(5);
        w_icode <= y86_fetch_pkg::I_RET;
        w_valm <= y86_fetch_pkg::IMEM_BYTES;
        run_cycle();
        w_icode <= y86_fetch_pkg::I_NOP;
        run_cycle();
        end_test();

        begin_test("random");
        build_random(10);
        load_program();
        run_until_halt(12);
        end_test();

        $display("summary: %0d clean, %0d with mismatches, %0d checker failures",
            clean_tests, bad_tests, u_fetch.u_fetch_checker.fail_count);
        if (bad_tests == 0 && u_fetch.u_fetch_checker.fail_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
hdl/y86_fetch_pkg.sv
hdl/pc_select.sv
hdl/imem.sv
hdl/inst_split.sv
hdl/fetch.sv
sim/fetch_checker.sv
sim/tb_fetch.sv
